// File: design/csr_pkg.sv
package csr_pkg;

    localparam int csr_w = 32;
    localparam int csr_num_w = 14;

    typedef enum logic [csr_num_w-1:0] {
        csr_crmd   = 14'h00,
        csr_prmd   = 14'h01,
        csr_ecfg   = 14'h04,
        csr_estat  = 14'h05,
        csr_era    = 14'h06,
        csr_badv   = 14'h07,
        csr_eentry = 14'h0c,
        csr_save0  = 14'h30,
        csr_tid    = 14'h40,
        csr_tcfg   = 14'h41,
        csr_tval   = 14'h42,
        csr_ticlr  = 14'h44
    } csr_num_e;

    typedef enum logic [5:0] {
        ecode_int = 6'h00,
        ecode_ade = 6'h08,
        ecode_ale = 6'h09,
        ecode_sys = 6'h0b,
        ecode_brk = 6'h0c,
        ecode_ine = 6'h0d
    } ecode_e;

    localparam int esubcode_w = 9;
    localparam logic [esubcode_w-1:0] esubcode_adef = '0;

    // interrupt lines in estat.is / ecfg.lie
    localparam int int_w = 13;
    localparam int int_timer = 11;

    localparam int crmd_plv_lo = 0;
    localparam int crmd_plv_hi = 1;
    localparam int crmd_ie_bit = 2;
    localparam int prmd_pplv_lo = 0;
    localparam int prmd_pplv_hi = 1;
    localparam int prmd_pie_bit = 2;
    localparam int estat_is_lo = 0;
    localparam int estat_is_hi = 12;
    localparam int estat_ecode_lo = 16;
    localparam int estat_ecode_hi = 21;
    localparam int estat_esub_lo = 22;
    localparam int estat_esub_hi = 30;
    localparam int eentry_va_lo = 6;
    localparam int tcfg_en_bit = 0;
    localparam int tcfg_periodic_bit = 1;
    localparam int tcfg_initval_lo = 2;
    localparam int tcfg_initval_hi = 31;
    localparam int ticlr_clr_bit = 0;

    // new bits where mask is set, old bits elsewhere
    function automatic logic [csr_w-1:0] mask_merge(
        input logic [csr_w-1:0] old_val,
        input logic [csr_w-1:0] mask,
        input logic [csr_w-1:0] wdata
    );
        return (mask & wdata) | (~mask & old_val);
    endfunction

endpackage

// File: design/csr_wr_if.sv
interface csr_wr_if;

    logic                          we;
    csr_pkg::csr_num_e             num;
    logic [csr_pkg::csr_w-1:0]     mask;
    logic [csr_pkg::csr_w-1:0]     wdata;

    modport src (
        output we,
        output num,
        output mask,
        output wdata
    );

    modport snk (
        input we,
        input num,
        input mask,
        input wdata
    );

endinterface

// File: design/csr_exc_regs.sv
module csr_exc_regs (
    input  logic                              clk,
    input  logic                              rst,
    csr_wr_if.snk                             wr,
    input  logic [csr_pkg::csr_num_w-1:0]     rnum,
    output logic [csr_pkg::csr_w-1:0]         rdata,
    input  logic                              exc,
    input  logic [5:0]                        exc_ecode,
    input  logic [csr_pkg::esubcode_w-1:0]    exc_esubcode,
    input  logic [csr_pkg::csr_w-1:0]         exc_pc,
    input  logic [csr_pkg::csr_w-1:0]         exc_badvaddr,
    input  logic                              ertn,
    input  logic                              timer_int,
    output logic                              has_int,
    output logic [csr_pkg::csr_w-1:0]         exc_entry,
    output logic [csr_pkg::csr_w-1:0]         exc_retaddr
);

    logic [1:0]                          crmd_plv;
    logic                                crmd_ie;
    logic [1:0]                          prmd_pplv;
    logic                                prmd_pie;
    logic [csr_pkg::int_w-1:0]           ecfg_lie;
    logic [1:0]                          estat_sw;
    logic [5:0]                          estat_ecode;
    logic [csr_pkg::esubcode_w-1:0]      estat_esub;
    logic [csr_pkg::int_w-1:0]           estat_is;
    logic [csr_pkg::csr_w-1:0]           era;
    logic [csr_pkg::csr_w-1:0]           badv;
    logic [csr_pkg::csr_w-1:csr_pkg::eentry_va_lo] eentry_va;

    logic [csr_pkg::csr_w-1:0] crmd_rval;
    logic [csr_pkg::csr_w-1:0] prmd_rval;
    logic [csr_pkg::csr_w-1:0] ecfg_rval;
    logic [csr_pkg::csr_w-1:0] estat_rval;
    logic [csr_pkg::csr_w-1:0] eentry_rval;

    logic [csr_pkg::csr_w-1:0] crmd_next;
    logic [csr_pkg::csr_w-1:0] prmd_next;
    logic [csr_pkg::csr_w-1:0] ecfg_next;
    logic [csr_pkg::csr_w-1:0] estat_next;
    logic [csr_pkg::csr_w-1:0] era_next;
    logic [csr_pkg::csr_w-1:0] badv_next;
    logic [csr_pkg::csr_w-1:0] eentry_next;

    // hw lines 9..2, bit 10 and ipi stay zero
    always_comb begin
        estat_is = '0;
        estat_is[1:0] = estat_sw;
        estat_is[csr_pkg::int_timer] = timer_int;
    end

    always_comb begin
        crmd_rval = '0;
        crmd_rval[csr_pkg::crmd_plv_hi:csr_pkg::crmd_plv_lo] = crmd_plv;
        crmd_rval[csr_pkg::crmd_ie_bit] = crmd_ie;
        prmd_rval = '0;
        prmd_rval[csr_pkg::prmd_pplv_hi:csr_pkg::prmd_pplv_lo] = prmd_pplv;
        prmd_rval[csr_pkg::prmd_pie_bit] = prmd_pie;
        ecfg_rval = '0;
        ecfg_rval[csr_pkg::int_w-1:0] = ecfg_lie;
        estat_rval = '0;
        estat_rval[csr_pkg::estat_is_hi:csr_pkg::estat_is_lo] = estat_is;
        estat_rval[csr_pkg::estat_ecode_hi:csr_pkg::estat_ecode_lo] = estat_ecode;
        estat_rval[csr_pkg::estat_esub_hi:csr_pkg::estat_esub_lo] = estat_esub;
        eentry_rval = '0;
        eentry_rval[csr_pkg::csr_w-1:csr_pkg::eentry_va_lo] = eentry_va;
    end

    assign crmd_next   = csr_pkg::mask_merge(crmd_rval, wr.mask, wr.wdata);
    assign prmd_next   = csr_pkg::mask_merge(prmd_rval, wr.mask, wr.wdata);
    assign ecfg_next   = csr_pkg::mask_merge(ecfg_rval, wr.mask, wr.wdata);
    assign estat_next  = csr_pkg::mask_merge(estat_rval, wr.mask, wr.wdata);
    assign era_next    = csr_pkg::mask_merge(era, wr.mask, wr.wdata);
    assign badv_next   = csr_pkg::mask_merge(badv, wr.mask, wr.wdata);
    assign eentry_next = csr_pkg::mask_merge(eentry_rval, wr.mask, wr.wdata);

    // exc beats ertn beats software write
    always_ff @(posedge clk) begin
        if (rst) begin
            crmd_plv <= '0;
            crmd_ie <= 1'b0;
        end else if (exc) begin
            crmd_plv <= '0;
            crmd_ie <= 1'b0;
        end else if (ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie <= prmd_pie;
        end else if (wr.we && wr.num == csr_pkg::csr_crmd) begin
            crmd_plv <= crmd_next[csr_pkg::crmd_plv_hi:csr_pkg::crmd_plv_lo];
            crmd_ie <= crmd_next[csr_pkg::crmd_ie_bit];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            prmd_pplv <= '0;
            prmd_pie <= 1'b0;
        end else if (exc) begin
            prmd_pplv <= crmd_plv;
            prmd_pie <= crmd_ie;
        end else if (wr.we && wr.num == csr_pkg::csr_prmd) begin
            prmd_pplv <= prmd_next[csr_pkg::prmd_pplv_hi:csr_pkg::prmd_pplv_lo];
            prmd_pie <= prmd_next[csr_pkg::prmd_pie_bit];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ecfg_lie <= '0;
            estat_sw <= '0;
            estat_ecode <= '0;
            estat_esub <= '0;
            era <= '0;
            eentry_va <= '0;
        end else begin
            if (wr.we && wr.num == csr_pkg::csr_ecfg) begin
                ecfg_lie <= ecfg_next[csr_pkg::int_w-1:0];
            end
            // only the two software lines are writable
            if (wr.we && wr.num == csr_pkg::csr_estat) begin
                estat_sw <= estat_next[1:0];
            end
            if (exc) begin
                estat_ecode <= exc_ecode;
                estat_esub <= exc_esubcode;
                era <= exc_pc;
            end else if (wr.we && wr.num == csr_pkg::csr_era) begin
                era <= era_next;
            end
            if (wr.we && wr.num == csr_pkg::csr_eentry) begin
                eentry_va <= eentry_next[csr_pkg::csr_w-1:csr_pkg::eentry_va_lo];
            end
        end
    end

    // fetch faults record the pc, misaligned data the access address
    always_ff @(posedge clk) begin
        if (exc && exc_ecode == csr_pkg::ecode_ade && exc_esubcode == csr_pkg::esubcode_adef) begin
            badv <= exc_pc;
        end else if (exc && exc_ecode == csr_pkg::ecode_ale) begin
            badv <= exc_badvaddr;
        end else if (!exc && wr.we && wr.num == csr_pkg::csr_badv) begin
            badv <= badv_next;
        end
    end

    always_comb begin
        case (rnum)
            csr_pkg::csr_crmd:   rdata = crmd_rval;
            csr_pkg::csr_prmd:   rdata = prmd_rval;
            csr_pkg::csr_ecfg:   rdata = ecfg_rval;
            csr_pkg::csr_estat:  rdata = estat_rval;
            csr_pkg::csr_era:    rdata = era;
            csr_pkg::csr_badv:   rdata = badv;
            csr_pkg::csr_eentry: rdata = eentry_rval;
            default:             rdata = '0;
        endcase
    end

    assign has_int = crmd_ie & (|(estat_is & ecfg_lie));
    assign exc_entry = eentry_rval;
    assign exc_retaddr = era;

endmodule

// File: design/csr_timer.sv
module csr_timer (
    input  logic                              clk,
    input  logic                              rst,
    csr_wr_if.snk                             wr,
    input  logic [csr_pkg::csr_num_w-1:0]     rnum,
    output logic [csr_pkg::csr_w-1:0]         rdata,
    output logic                              timer_int
);

    logic [csr_pkg::csr_w-1:0] tid;
    logic                      tcfg_en;
    logic                      tcfg_periodic;
    logic [csr_pkg::tcfg_initval_hi-csr_pkg::tcfg_initval_lo:0] tcfg_initval;
    logic [csr_pkg::csr_w-1:0] timer_cnt;

    logic [csr_pkg::csr_w-1:0] tcfg_rval;
    logic [csr_pkg::csr_w-1:0] tcfg_next;
    logic [csr_pkg::csr_w-1:0] tid_next;
    logic                      tcfg_wr;
    logic                      ticlr_next;
    logic                      clr_req;

    assign tcfg_rval = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_next = csr_pkg::mask_merge(tcfg_rval, wr.mask, wr.wdata);
    assign tid_next = csr_pkg::mask_merge(tid, wr.mask, wr.wdata);
    assign tcfg_wr = wr.we && wr.num == csr_pkg::csr_tcfg;

    // ticlr always reads zero, so the merge reduces to mask & wdata
    assign ticlr_next = wr.mask[csr_pkg::ticlr_clr_bit] & wr.wdata[csr_pkg::ticlr_clr_bit];
    assign clr_req = wr.we && wr.num == csr_pkg::csr_ticlr && ticlr_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            tid <= '0;
            tcfg_en <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval <= '0;
        end else begin
            if (wr.we && wr.num == csr_pkg::csr_tid) begin
                tid <= tid_next;
            end
            if (tcfg_wr) begin
                tcfg_en <= tcfg_next[csr_pkg::tcfg_en_bit];
                tcfg_periodic <= tcfg_next[csr_pkg::tcfg_periodic_bit];
                tcfg_initval <= tcfg_next[csr_pkg::tcfg_initval_hi:csr_pkg::tcfg_initval_lo];
            end
        end
    end

    // all ones means stopped
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_cnt <= '1;
        end else if (tcfg_wr && tcfg_next[csr_pkg::tcfg_en_bit]) begin
            timer_cnt <= {tcfg_next[csr_pkg::tcfg_initval_hi:csr_pkg::tcfg_initval_lo], 2'b00};
        end else if (tcfg_en && timer_cnt != '1) begin
            if (timer_cnt == '0 && tcfg_periodic) begin
                timer_cnt <= {tcfg_initval, 2'b00};
            end else begin
                timer_cnt <= timer_cnt - 1'b1;
            end
        end
    end

    // expiry wins over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_int <= 1'b0;
        end else if (timer_cnt == '0) begin
            timer_int <= 1'b1;
        end else if (clr_req) begin
            timer_int <= 1'b0;
        end
    end

    always_comb begin
        case (rnum)
            csr_pkg::csr_tid:  rdata = tid;
            csr_pkg::csr_tcfg: rdata = tcfg_rval;
            csr_pkg::csr_tval: rdata = timer_cnt;
            default:           rdata = '0;
        endcase
    end

endmodule

// File: design/csr_save_regs.sv
module csr_save_regs #(
    parameter int num_save = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    csr_wr_if.snk                             wr,
    input  logic [csr_pkg::csr_num_w-1:0]     rnum,
    output logic [csr_pkg::csr_w-1:0]         rdata
);

    logic [csr_pkg::csr_w-1:0] save_q [num_save];

    // csr number of scratch register i
    function automatic csr_pkg::csr_num_e save_num(input int i);
        return csr_pkg::csr_num_e'(csr_pkg::csr_save0 + i);
    endfunction

    always_ff @(posedge clk) begin
        for (int i = 0; i < num_save; i++) begin
            if (rst) begin
                save_q[i] <= '0;
            end else if (wr.we && wr.num == save_num(i)) begin
                save_q[i] <= csr_pkg::mask_merge(save_q[i], wr.mask, wr.wdata);
            end
        end
    end

    always_comb begin
        rdata = '0;
        for (int i = 0; i < num_save; i++) begin
            if (rnum == save_num(i)) begin
                rdata = save_q[i];
            end
        end
    end

endmodule

// File: design/csr_file.sv
module csr_file #(
    parameter int num_save = 4
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              csr_we,
    input  logic [csr_pkg::csr_num_w-1:0]     csr_wnum,
    input  logic [csr_pkg::csr_w-1:0]         csr_wmask,
    input  logic [csr_pkg::csr_w-1:0]         csr_wval,
    input  logic [csr_pkg::csr_num_w-1:0]     csr_rnum,
    output logic [csr_pkg::csr_w-1:0]         csr_rval,
    input  logic                              exc,
    input  logic [5:0]                        exc_ecode,
    input  logic [csr_pkg::esubcode_w-1:0]    exc_esubcode,
    input  logic [csr_pkg::csr_w-1:0]         exc_pc,
    input  logic [csr_pkg::csr_w-1:0]         exc_badvaddr,
    input  logic                              ertn,
    output logic                              has_int,
    output logic [csr_pkg::csr_w-1:0]         exc_entry,
    output logic [csr_pkg::csr_w-1:0]         exc_retaddr
);

    logic [csr_pkg::csr_w-1:0] exc_rdata;
    logic [csr_pkg::csr_w-1:0] timer_rdata;
    logic [csr_pkg::csr_w-1:0] save_rdata;
    logic                      timer_int;

    csr_wr_if wr_bus ();

    assign wr_bus.we = csr_we;
    assign wr_bus.num = csr_pkg::csr_num_e'(csr_wnum);
    assign wr_bus.mask = csr_wmask;
    assign wr_bus.wdata = csr_wval;

    csr_exc_regs i_exc_regs (
        .clk          (clk),
        .rst          (rst),
        .wr           (wr_bus.snk),
        .rnum         (csr_rnum),
        .rdata        (exc_rdata),
        .exc          (exc),
        .exc_ecode    (exc_ecode),
        .exc_esubcode (exc_esubcode),
        .exc_pc       (exc_pc),
        .exc_badvaddr (exc_badvaddr),
        .ertn         (ertn),
        .timer_int    (timer_int),
        .has_int      (has_int),
        .exc_entry    (exc_entry),
        .exc_retaddr  (exc_retaddr)
    );

    csr_timer i_timer (
        .clk       (clk),
        .rst       (rst),
        .wr        (wr_bus.snk),
        .rnum      (csr_rnum),
        .rdata     (timer_rdata),
        .timer_int (timer_int)
    );

    csr_save_regs #(
        .num_save (num_save)
    ) i_save_regs (
        .clk   (clk),
        .rst   (rst),
        .wr    (wr_bus.snk),
        .rnum  (csr_rnum),
        .rdata (save_rdata)
    );

    // groups return zero for numbers they do not own
    assign csr_rval = exc_rdata | timer_rdata | save_rdata;

endmodule

// File: dv/tb_csr_file.sv
module tb_csr_file;

    timeunit 1ns;
    timeprecision 100ps;

    logic                               clk;
    logic                               rst;
    logic                               csr_we;
    logic [csr_pkg::csr_num_w-1:0]      csr_wnum;
    logic [csr_pkg::csr_w-1:0]          csr_wmask;
    logic [csr_pkg::csr_w-1:0]          csr_wval;
    logic [csr_pkg::csr_num_w-1:0]      csr_rnum;
    logic [csr_pkg::csr_w-1:0]          csr_rval;
    logic                               exc;
    logic [5:0]                         exc_ecode;
    logic [csr_pkg::esubcode_w-1:0]     exc_esubcode;
    logic [csr_pkg::csr_w-1:0]          exc_pc;
    logic [csr_pkg::csr_w-1:0]          exc_badvaddr;
    logic                               ertn;
    logic                               has_int;
    logic [csr_pkg::csr_w-1:0]          exc_entry;
    logic [csr_pkg::csr_w-1:0]          exc_retaddr;

    integer         fd;
    integer         rc;
    integer         op_count;
    string          cmd;
    logic [8*256-1:0] line;
    logic [31:0]    a0;
    logic [31:0]    a1;
    logic [31:0]    a2;
    logic [31:0]    a3;
    logic [31:0]    lcg_state;
    // expected contents of every csr number after masked writes
    logic [31:0]    shadow [0:16383];

    csr_file #(
        .num_save (4)
    ) i_csr_file (
        .clk          (clk),
        .rst          (rst),
        .csr_we       (csr_we),
        .csr_wnum     (csr_wnum),
        .csr_wmask    (csr_wmask),
        .csr_wval     (csr_wval),
        .csr_rnum     (csr_rnum),
        .csr_rval     (csr_rval),
        .exc          (exc),
        .exc_ecode    (exc_ecode),
        .exc_esubcode (exc_esubcode),
        .exc_pc       (exc_pc),
        .exc_badvaddr (exc_badvaddr),
        .ertn         (ertn),
        .has_int      (has_int),
        .exc_entry    (exc_entry),
        .exc_retaddr  (exc_retaddr)
    );

    always #50 clk = ~clk;

    function logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // eentry keeps its low 6 bits at zero
    function automatic logic [31:0] writable_bits(input logic [13:0] num);
        return (num == 14'h00c) ? 32'hffff_ffc0 : 32'hffff_ffff;
    endfunction

    task check(input string name, input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // wait for the falling edge and drop all strobes
    task start_cycle();
        @(negedge clk);
        csr_we = 1'b0;
        exc = 1'b0;
        ertn = 1'b0;
    endtask

    task write_csr(input logic [13:0] num, input logic [31:0] mask, input logic [31:0] val);
        start_cycle();
        csr_we = 1'b1;
        csr_wnum = num;
        csr_wmask = mask;
        csr_wval = val;
        shadow[num] = ((mask & val) | (~mask & shadow[num])) & writable_bits(num);
    endtask

    task read_csr(input logic [13:0] num, input logic [31:0] expected);
        start_cycle();
        csr_rnum = num;
        #1;
        check($sformatf("op %0d read %h", op_count, num), expected, csr_rval);
    endtask

    task wait_for_int(input integer limit);
        integer n;
        n = 0;
        start_cycle();
        while (has_int !== 1'b1) begin
            if (n >= limit) begin
                $display("has_int never rose within %0d cycles (op %0d)", limit, op_count);
                $display("Simulation failed");
                $fatal(1, "interrupt wait timed out");
            end else begin
                start_cycle();
                n = n + 1;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        csr_we = 1'b0;
        csr_wnum = '0;
        csr_wmask = '0;
        csr_wval = '0;
        csr_rnum = '0;
        exc = 1'b0;
        exc_ecode = '0;
        exc_esubcode = '0;
        exc_pc = '0;
        exc_badvaddr = '0;
        ertn = 1'b0;
        lcg_state = 32'd4;
        op_count = 0;
        for (int i = 0; i < 16384; i++) begin
            shadow[i] = '0;
        end
        fd = $fopen("dv/csr_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file dv/csr_vectors.txt");
            $display("Simulation failed");
            $fatal(1, "no vectors");
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;

        rc = $fscanf(fd, "%s", cmd);
        while (rc == 1) begin
            op_count = op_count + 1;
            case (cmd)
                "#": rc = $fgets(line, fd);
                "write": begin
                    rc = $fscanf(fd, "%h %h %h", a0, a1, a2);
                    write_csr(a0[13:0], a1, a2);
                end
                "read": begin
                    rc = $fscanf(fd, "%h %h", a0, a1);
                    read_csr(a0[13:0], a1);
                end
                "rndwr": begin
                    rc = $fscanf(fd, "%h", a0);
                    a1 = next_random();
                    a2 = next_random();
                    write_csr(a0[13:0], a1, a2);
                    read_csr(a0[13:0], shadow[a0[13:0]]);
                end
                "exc": begin
                    rc = $fscanf(fd, "%h %h %h %h", a0, a1, a2, a3);
                    start_cycle();
                    exc = 1'b1;
                    exc_ecode = a0[5:0];
                    exc_esubcode = a1[8:0];
                    exc_pc = a2;
                    exc_badvaddr = a3;
                end
                "ertn": begin
                    start_cycle();
                    ertn = 1'b1;
                end
                "idle": begin
                    rc = $fscanf(fd, "%d", a0);
                    start_cycle();
                    repeat (a0 - 1) @(negedge clk);
                end
                "hasint": begin
                    rc = $fscanf(fd, "%h", a0);
                    start_cycle();
                    #1;
                    check($sformatf("op %0d has_int", op_count), a0, {31'b0, has_int});
                end
                "outs": begin
                    rc = $fscanf(fd, "%h %h", a0, a1);
                    start_cycle();
                    #1;
                    check($sformatf("op %0d exc_entry", op_count), a0, exc_entry);
                    check($sformatf("op %0d exc_retaddr", op_count), a1, exc_retaddr);
                end
                "waitint": begin
                    rc = $fscanf(fd, "%d", a0);
                    wait_for_int(a0);
                end
                default: begin
                    $display("unknown command '%s' in the vector file (op %0d)", cmd, op_count);
                    $display("Simulation failed");
                    $fatal(1, "bad vector file");
                end
            endcase
            rc = $fscanf(fd, "%s", cmd);
        end
        $fclose(fd);
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: dv/csr_vectors.txt
# columns: write num mask val | read num expected | rndwr num | exc ecode esubcode pc badv
# ertn | idle cycles(dec) | hasint expected | outs entry retaddr | waitint limit(dec)
read 0 00000000
read 1 00000000
read 41 00000000
read 42 ffffffff
hasint 0
rndwr 30
rndwr 30
rndwr 31
rndwr 31
rndwr 32
rndwr 32
rndwr 33
rndwr 33
rndwr c
rndwr c
rndwr 40
rndwr 40
write 0 ffffffff 00000007
read 0 00000007
write c ffffffff 1c008000
exc 9 0 1c000100 00001234
read 0 00000000
read 1 00000007
read 5 00090000
read 6 1c000100
read 7 00001234
outs 1c008000 1c000100
ertn
read 0 00000007
exc 8 0 1c000200 deadbeef
read 7 1c000200
read 5 00080000
ertn
read 0 00000007
write 4 ffffffff 00000001
hasint 0
write 5 00000003 00000001
hasint 1
read 5 00080001
write 0 00000004 00000000
hasint 0
write 0 00000004 00000004
hasint 1
write 4 ffffffff 00000000
hasint 0
write 5 00000003 00000000
write 4 ffffffff 00000800
write 41 ffffffff 00000101
read 42 00000100
idle 3
read 42 000000fc
waitint 400
read 5 00080800
read 42 ffffffff
write 44 00000001 00000001
hasint 0
read 5 00080000

// File: files.f
design/csr_pkg.sv
design/csr_wr_if.sv
design/csr_exc_regs.sv
design/csr_timer.sv
design/csr_save_regs.sv
design/csr_file.sv
dv/tb_csr_file.sv

// File: run.sh
#!/bin/sh
# build and run the csr file testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_csr_file -f files.f -o sim_csr_file
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_csr_file)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^Simulation passed$"; then
    exit 0
else
    exit 1
fi
